// ==== hdl/mips_lite_pkg.sv ====
// mips lite shared definitions
package mips_lite_pkg;

	//////////////////////////////////////////////////
	// field and data widths
	//////////////////////////////////////////////////
	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [15:0] imm_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;
	typedef logic [4:0]  shamt_t;

	// architectural register count
	localparam int REG_COUNT = 32;

	// primary opcodes
	localparam opcode_t OP_RTYPE = 6'h00;
	localparam opcode_t OP_ADDI  = 6'h08;
	localparam opcode_t OP_SLTI  = 6'h0A;
	localparam opcode_t OP_ANDI  = 6'h0C;
	localparam opcode_t OP_ORI   = 6'h0D;
	localparam opcode_t OP_XORI  = 6'h0E;
	localparam opcode_t OP_LUI   = 6'h0F;

	// r-type function codes
	localparam funct_t FN_SLL = 6'h00;
	localparam funct_t FN_SRL = 6'h02;
	localparam funct_t FN_ADD = 6'h20;
	localparam funct_t FN_SUB = 6'h22;
	localparam funct_t FN_AND = 6'h24;
	localparam funct_t FN_OR  = 6'h25;
	localparam funct_t FN_XOR = 6'h26;
	localparam funct_t FN_SLT = 6'h2A;

	// alu operations
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_LUI
	} alu_op_e;

	//////////////////////////////////////////////////
	// stage structs
	//////////////////////////////////////////////////
	// decoded control bits, 8 bits
	typedef struct packed {
		logic    reg_dst;
		logic    alu_src;
		logic    zero_ext;
		logic    reg_write;
		alu_op_e alu_op;
	} ctrl_t;

	// decode register contents, 125 bits
	typedef struct packed {
		logic      valid;
		ctrl_t     ctrl;
		reg_addr_t rs_addr;
		reg_addr_t rt_addr;
		reg_addr_t dest;
		word_t     rs_val;
		word_t     rt_val;
		word_t     imm_ext;
		shamt_t    shamt;
	} dec_out_t;

	// execute and writeback register contents, 39 bits
	typedef struct packed {
		logic      valid;
		logic      reg_write;
		reg_addr_t dest;
		word_t     result;
	} exe_out_t;

endpackage

// ==== hdl/control_unit.sv ====
// mips lite control decoder
`timescale 1ns/10ps
module control_unit (
	input  mips_lite_pkg::opcode_t i_opcode,
	input  mips_lite_pkg::funct_t  i_funct,
	output mips_lite_pkg::ctrl_t   o_ctrl
);

	always_comb
	begin
		// defaults describe a no-op that writes nothing
		o_ctrl.reg_dst   = 1'b0;
		o_ctrl.alu_src   = 1'b0;
		o_ctrl.zero_ext  = 1'b0;
		o_ctrl.reg_write = 1'b0;
		o_ctrl.alu_op    = mips_lite_pkg::ALU_ADD;
		case (i_opcode)
			mips_lite_pkg::OP_RTYPE:
			begin
				// rd is the destination, second operand from rt
				o_ctrl.reg_dst   = 1'b1;
				o_ctrl.reg_write = 1'b1;
				case (i_funct)
					mips_lite_pkg::FN_ADD: o_ctrl.alu_op = mips_lite_pkg::ALU_ADD;
					mips_lite_pkg::FN_SUB: o_ctrl.alu_op = mips_lite_pkg::ALU_SUB;
					mips_lite_pkg::FN_AND: o_ctrl.alu_op = mips_lite_pkg::ALU_AND;
					mips_lite_pkg::FN_OR:  o_ctrl.alu_op = mips_lite_pkg::ALU_OR;
					mips_lite_pkg::FN_XOR: o_ctrl.alu_op = mips_lite_pkg::ALU_XOR;
					mips_lite_pkg::FN_SLT: o_ctrl.alu_op = mips_lite_pkg::ALU_SLT;
					mips_lite_pkg::FN_SLL: o_ctrl.alu_op = mips_lite_pkg::ALU_SLL;
					mips_lite_pkg::FN_SRL: o_ctrl.alu_op = mips_lite_pkg::ALU_SRL;
					// unknown function code retires silently
					default:               o_ctrl.reg_write = 1'b0;
				endcase
			end
			// arithmetic immediates keep the sign
			mips_lite_pkg::OP_ADDI:
			begin
				o_ctrl.alu_src   = 1'b1;
				o_ctrl.reg_write = 1'b1;
				o_ctrl.alu_op    = mips_lite_pkg::ALU_ADD;
			end
			mips_lite_pkg::OP_SLTI:
			begin
				o_ctrl.alu_src   = 1'b1;
				o_ctrl.reg_write = 1'b1;
				o_ctrl.alu_op    = mips_lite_pkg::ALU_SLT;
			end
			// logic immediates and lui are zero extended
			mips_lite_pkg::OP_ANDI, mips_lite_pkg::OP_ORI,
			mips_lite_pkg::OP_XORI, mips_lite_pkg::OP_LUI:
			begin
				o_ctrl.alu_src   = 1'b1;
				o_ctrl.zero_ext  = 1'b1;
				o_ctrl.reg_write = 1'b1;
				case (i_opcode)
					mips_lite_pkg::OP_ANDI: o_ctrl.alu_op = mips_lite_pkg::ALU_AND;
					mips_lite_pkg::OP_ORI:  o_ctrl.alu_op = mips_lite_pkg::ALU_OR;
					mips_lite_pkg::OP_XORI: o_ctrl.alu_op = mips_lite_pkg::ALU_XOR;
					default:                o_ctrl.alu_op = mips_lite_pkg::ALU_LUI;
				endcase
			end
			default:
			begin
				// unsupported opcode, keep the no-op defaults
				o_ctrl.reg_write = 1'b0;
			end
		endcase
	end

endmodule

// ==== hdl/register_bank.sv ====
// mips lite register file
`timescale 1ns/10ps
module register_bank (
	input  logic                     i_clk,
	input  mips_lite_pkg::reg_addr_t i_rd_addr_a,
	input  mips_lite_pkg::reg_addr_t i_rd_addr_b,
	input  logic                     i_we,
	input  mips_lite_pkg::reg_addr_t i_wr_addr,
	input  mips_lite_pkg::word_t     i_wr_data,
	output mips_lite_pkg::word_t     o_rd_data_a,
	output mips_lite_pkg::word_t     o_rd_data_b
);

	// r1..r31 only, r0 is hardwired
	mips_lite_pkg::word_t regs_q [1:mips_lite_pkg::REG_COUNT-1];

	// one read port with write-first bypass
	function automatic mips_lite_pkg::word_t read_port(
		input mips_lite_pkg::reg_addr_t addr
	);
		mips_lite_pkg::word_t data;
		if (addr == '0)
			data = '0;
		else if (i_we && (addr == i_wr_addr))
			data = i_wr_data;
		else
			data = regs_q[addr];
		return data;
	endfunction

	always_ff @(posedge i_clk)
	begin
		// writes to r0 are dropped
		if (i_we && (i_wr_addr != '0))
			regs_q[i_wr_addr] <= i_wr_data;
	end

	// pending write is visible to decode in the same cycle
	assign o_rd_data_a = read_port(i_rd_addr_a);
	assign o_rd_data_b = read_port(i_rd_addr_b);

endmodule

// ==== hdl/decode_stage.sv ====
// mips lite decode stage
`timescale 1ns/10ps
module decode_stage (
	input  logic                    i_clk,
	input  logic                    i_rst_n,
	input  logic                    i_instr_valid,
	input  mips_lite_pkg::word_t    i_instr,
	input  mips_lite_pkg::exe_out_t i_wb,
	output mips_lite_pkg::dec_out_t o_dec
);

	//////////////////////////////////////////////////
	// instruction fields
	//////////////////////////////////////////////////
	mips_lite_pkg::opcode_t   opcode;
	mips_lite_pkg::funct_t    funct;
	mips_lite_pkg::reg_addr_t rs_addr;
	mips_lite_pkg::reg_addr_t rt_addr;
	mips_lite_pkg::reg_addr_t rd_addr;
	mips_lite_pkg::shamt_t    shamt;
	mips_lite_pkg::imm_t      imm;

	// derived values
	mips_lite_pkg::ctrl_t     ctrl;
	mips_lite_pkg::reg_addr_t dest;
	mips_lite_pkg::word_t     imm_ext;
	mips_lite_pkg::word_t     rs_val;
	mips_lite_pkg::word_t     rt_val;

	// control part of the decode register
	logic                     valid_q;
	mips_lite_pkg::ctrl_t     ctrl_q;
	// payload part
	mips_lite_pkg::reg_addr_t rs_addr_q;
	mips_lite_pkg::reg_addr_t rt_addr_q;
	mips_lite_pkg::reg_addr_t dest_q;
	mips_lite_pkg::word_t     rs_val_q;
	mips_lite_pkg::word_t     rt_val_q;
	mips_lite_pkg::word_t     imm_ext_q;
	mips_lite_pkg::shamt_t    shamt_q;

	// field split
	assign opcode  = i_instr[31:26];
	assign rs_addr = i_instr[25:21];
	assign rt_addr = i_instr[20:16];
	assign rd_addr = i_instr[15:11];
	assign shamt   = i_instr[10:6];
	assign funct   = i_instr[5:0];
	assign imm     = i_instr[15:0];

	// r-type writes rd, i-type writes rt
	assign dest    = ctrl.reg_dst ? rd_addr : rt_addr;
	// immediate extension as control asks
	assign imm_ext = ctrl.zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};

	control_unit u_control (
		.i_opcode (opcode),
		.i_funct  (funct),
		.o_ctrl   (ctrl)
	);

	// write port driven from the writeback register
	register_bank u_register_bank (
		.i_clk       (i_clk),
		.i_rd_addr_a (rs_addr),
		.i_rd_addr_b (rt_addr),
		.i_we        (i_wb.valid & i_wb.reg_write),
		.i_wr_addr   (i_wb.dest),
		.i_wr_data   (i_wb.result),
		.o_rd_data_a (rs_val),
		.o_rd_data_b (rt_val)
	);

	//////////////////////////////////////////////////
	// decode register
	//////////////////////////////////////////////////
	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			valid_q <= 1'b0;
			ctrl_q  <= '0;
		end
		else
		begin
			valid_q <= i_instr_valid;
			ctrl_q  <= ctrl;
		end
	end

	// operands and addresses, qualified by valid downstream
	always_ff @(posedge i_clk)
	begin
		rs_addr_q <= rs_addr;
		rt_addr_q <= rt_addr;
		dest_q    <= dest;
		rs_val_q  <= rs_val;
		rt_val_q  <= rt_val;
		imm_ext_q <= imm_ext;
		shamt_q   <= shamt;
	end

	assign o_dec = '{valid: valid_q, ctrl: ctrl_q, rs_addr: rs_addr_q, rt_addr: rt_addr_q,
		dest: dest_q, rs_val: rs_val_q, rt_val: rt_val_q, imm_ext: imm_ext_q, shamt: shamt_q};

endmodule

// ==== hdl/execute_stage.sv ====
// mips lite execute stage
`timescale 1ns/10ps
module execute_stage (
	input  logic                    i_clk,
	input  logic                    i_rst_n,
	input  mips_lite_pkg::dec_out_t i_dec,
	input  mips_lite_pkg::exe_out_t i_wb,
	output mips_lite_pkg::exe_out_t o_exe
);

	// forwarded operands
	mips_lite_pkg::word_t     rs_fwd;
	mips_lite_pkg::word_t     rt_fwd;
	mips_lite_pkg::word_t     op_b;
	mips_lite_pkg::word_t     alu_result;

	// execute register
	logic                     valid_q;
	logic                     reg_write_q;
	mips_lite_pkg::reg_addr_t dest_q;
	mips_lite_pkg::word_t     result_q;

	// a producer hits when valid, writing and same non-zero dest
	function automatic mips_lite_pkg::word_t forward(
		input mips_lite_pkg::reg_addr_t addr,
		input mips_lite_pkg::word_t     dec_val,
		input mips_lite_pkg::exe_out_t  exe,
		input mips_lite_pkg::exe_out_t  wb
	);
		mips_lite_pkg::word_t val;
		// youngest result wins
		if (exe.valid && exe.reg_write && (exe.dest != '0) && (exe.dest == addr))
			val = exe.result;
		else if (wb.valid && wb.reg_write && (wb.dest != '0) && (wb.dest == addr))
			val = wb.result;
		else
			val = dec_val;
		return val;
	endfunction

	assign rs_fwd = forward(i_dec.rs_addr, i_dec.rs_val, o_exe, i_wb);
	assign rt_fwd = forward(i_dec.rt_addr, i_dec.rt_val, o_exe, i_wb);
	// immediate replaces rt for i-type
	assign op_b   = i_dec.ctrl.alu_src ? i_dec.imm_ext : rt_fwd;

	//////////////////////////////////////////////////
	// alu
	//////////////////////////////////////////////////
	always_comb
	begin
		case (i_dec.ctrl.alu_op)
			mips_lite_pkg::ALU_ADD: alu_result = rs_fwd + op_b;
			mips_lite_pkg::ALU_SUB: alu_result = rs_fwd - op_b;
			mips_lite_pkg::ALU_AND: alu_result = rs_fwd & op_b;
			mips_lite_pkg::ALU_OR:  alu_result = rs_fwd | op_b;
			mips_lite_pkg::ALU_XOR: alu_result = rs_fwd ^ op_b;
			// signed compare for slt and slti
			mips_lite_pkg::ALU_SLT: alu_result = {31'd0, $signed(rs_fwd) < $signed(op_b)};
			// shifts take rt by shamt
			mips_lite_pkg::ALU_SLL: alu_result = rt_fwd << i_dec.shamt;
			mips_lite_pkg::ALU_SRL: alu_result = rt_fwd >> i_dec.shamt;
			// immediate into the upper half
			mips_lite_pkg::ALU_LUI: alu_result = {op_b[15:0], 16'h0000};
			default:                alu_result = '0;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			valid_q     <= 1'b0;
			reg_write_q <= 1'b0;
		end
		else
		begin
			valid_q     <= i_dec.valid;
			reg_write_q <= i_dec.valid & i_dec.ctrl.reg_write;
		end
	end

	always_ff @(posedge i_clk)
	begin
		dest_q   <= i_dec.dest;
		result_q <= alu_result;
	end

	assign o_exe = '{valid: valid_q, reg_write: reg_write_q, dest: dest_q, result: result_q};

endmodule

// ==== hdl/writeback_stage.sv ====
// mips lite writeback stage
`timescale 1ns/10ps
module writeback_stage (
	input  logic                    i_clk,
	input  logic                    i_rst_n,
	input  mips_lite_pkg::exe_out_t i_exe,
	output mips_lite_pkg::exe_out_t o_wb,
	output mips_lite_pkg::word_t    o_retired_count
);

	logic                     valid_q;
	logic                     we_q;
	mips_lite_pkg::reg_addr_t dest_q;
	mips_lite_pkg::word_t     data_q;
	mips_lite_pkg::word_t     count_q;

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			valid_q <= 1'b0;
			we_q    <= 1'b0;
			count_q <= '0;
		end
		else
		begin
			valid_q <= i_exe.valid;
			// r0 destination never writes
			we_q    <= i_exe.valid & i_exe.reg_write & (i_exe.dest != '0);
			// one step per retirement leaving this register
			if (valid_q)
				count_q <= count_q + 32'd1;
		end
	end

	always_ff @(posedge i_clk)
	begin
		dest_q <= i_exe.dest;
		data_q <= i_exe.result;
	end

	assign o_wb            = '{valid: valid_q, reg_write: we_q, dest: dest_q, result: data_q};
	assign o_retired_count = count_q;

endmodule

// ==== hdl/mips_lite_top.sv ====
// mips lite core top
`timescale 1ns/10ps
module mips_lite_top (
	input  logic                     i_clk,
	input  logic                     i_rst_n,
	input  logic                     i_instr_valid,
	input  mips_lite_pkg::word_t     i_instr,
	output logic                     o_wb_valid,
	output logic                     o_wb_we,
	output mips_lite_pkg::reg_addr_t o_wb_addr,
	output mips_lite_pkg::word_t     o_wb_data,
	output mips_lite_pkg::word_t     o_retired_count
);

	//////////////////////////////////////////////////
	// stage to stage buses
	//////////////////////////////////////////////////
	mips_lite_pkg::dec_out_t dec;
	mips_lite_pkg::exe_out_t exe;
	// writeback copy, fed back to decode and execute
	mips_lite_pkg::exe_out_t wb;

	decode_stage u_decode (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_instr_valid (i_instr_valid),
		.i_instr       (i_instr),
		.i_wb          (wb),
		.o_dec         (dec)
	);

	execute_stage u_execute (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_dec   (dec),
		.i_wb    (wb),
		.o_exe   (exe)
	);

	writeback_stage u_writeback (
		.i_clk           (i_clk),
		.i_rst_n         (i_rst_n),
		.i_exe           (exe),
		.o_wb            (wb),
		.o_retired_count (o_retired_count)
	);

	// retired result onto the top ports
	assign o_wb_valid = wb.valid;
	assign o_wb_we    = wb.reg_write;
	assign o_wb_addr  = wb.dest;
	assign o_wb_data  = wb.result;

endmodule

// ==== verification/mips_lite_tb.sv ====
// mips lite testbench
`timescale 1ns/10ps
module mips_lite_tb;

	// expected writeback of one instruction
	typedef struct packed {
		logic                     we;
		mips_lite_pkg::reg_addr_t dest;
		mips_lite_pkg::word_t     data;
	} expect_t;

	// dut signals
	logic                     i_clk = 1'b0;
	logic                     i_rst_n;
	logic                     i_instr_valid;
	mips_lite_pkg::word_t     i_instr;
	logic                     o_wb_valid;
	logic                     o_wb_we;
	mips_lite_pkg::reg_addr_t o_wb_addr;
	mips_lite_pkg::word_t     o_wb_data;
	mips_lite_pkg::word_t     o_retired_count;

	// program and expected results from the data file
	string                name_list [$];
	mips_lite_pkg::word_t instr_list [$];
	expect_t              exp_list [$];
	// in-flight instruction indices in program order
	int                   pending [$];

	mips_lite_pkg::word_t rng_state;
	int                   cycle_limit;
	int                   pass_count;
	int                   fail_count;
	bit                   test_ok;

	mips_lite_top dut0 (
		.i_clk           (i_clk),
		.i_rst_n         (i_rst_n),
		.i_instr_valid   (i_instr_valid),
		.i_instr         (i_instr),
		.o_wb_valid      (o_wb_valid),
		.o_wb_we         (o_wb_we),
		.o_wb_addr       (o_wb_addr),
		.o_wb_data       (o_wb_data),
		.o_retired_count (o_retired_count)
	);

	// 100 ns clock
	initial
	begin
		forever #50 i_clk = ~i_clk;
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////
	// 32-bit xorshift step
	function automatic mips_lite_pkg::word_t xorshift32(input mips_lite_pkg::word_t x);
		mips_lite_pkg::word_t y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_flag(input string name, input string what, input logic expected,
		input logic actual);
		if (actual !== expected)
		begin
			$display("** Error %s %s: expected %b, actual %b", name, what, expected, actual);
			test_ok = 1'b0;
		end
	endtask

	task automatic check_addr(input string name, input mips_lite_pkg::reg_addr_t expected,
		input mips_lite_pkg::reg_addr_t actual);
		if (actual !== expected)
		begin
			$display("** Error %s dest: expected r%0d, actual r%0d", name, expected, actual);
			test_ok = 1'b0;
		end
	endtask

	task automatic check_word(input string name, input string what,
		input mips_lite_pkg::word_t expected, input mips_lite_pkg::word_t actual);
		if (actual !== expected)
		begin
			$display("** Error %s %s: expected %h, actual %h", name, what, expected, actual);
			test_ok = 1'b0;
		end
	endtask

	// one status line per finished test
	task automatic finish_test(input string name);
		if (test_ok)
		begin
			pass_count++;
			$display("ok      %s", name);
		end
		else
		begin
			fail_count++;
			$display("failed  %s", name);
		end
	endtask

	// parse the data file and skip comment and blank lines
	task automatic load_program(output bit ok);
		int                       fd;
		int                       fields;
		logic [8*160-1:0]         line_buf;
		string                    name_s;
		mips_lite_pkg::word_t     instr_v;
		logic                     we_v;
		mips_lite_pkg::reg_addr_t dest_v;
		mips_lite_pkg::word_t     data_v;
		expect_t                  e;
		fd = $fopen("verification/mips_lite_testdata.txt", "r");
		ok = 1'b0;
		if (fd == 0)
			$display("could not open verification/mips_lite_testdata.txt");
		else
		begin
			while ($fgets(line_buf, fd) != 0)
			begin
				fields = $sscanf(line_buf, "%s %h %d %d %h", name_s, instr_v, we_v, dest_v,
					data_v);
				if (fields == 5 && name_s.getc(0) != "/")
				begin
					e.we   = we_v;
					e.dest = dest_v;
					e.data = data_v;
					name_list.push_back(name_s);
					instr_list.push_back(instr_v);
					exp_list.push_back(e);
				end
			end
			$fclose(fd);
			ok = (instr_list.size() > 0);
			if (!ok)
				$display("the data file holds no instructions");
		end
	endtask

	// compare the head of the queue with a retiring instruction
	task automatic observe_writeback();
		int idx;
		if (o_wb_valid !== 1'b0)
		begin
			if (pending.size() == 0)
			begin
				$display("unexpected retirement to r%0d with no instruction pending", o_wb_addr);
				fail_count++;
			end
			else
			begin
				idx = pending.pop_front();
				test_ok = 1'b1;
				check_flag(name_list[idx], "we", exp_list[idx].we, o_wb_we);
				// dest and data only mean something for a real write
				if (exp_list[idx].we)
				begin
					check_addr(name_list[idx], exp_list[idx].dest, o_wb_addr);
					check_word(name_list[idx], "data", exp_list[idx].data, o_wb_data);
				end
				finish_test(name_list[idx]);
			end
		end
	endtask

	// sample outputs on the falling edge before inputs change
	task automatic next_cycle();
		@(negedge i_clk);
		observe_writeback();
	endtask

	task automatic check_reset_state();
		check_flag("reset", "wb_valid", 1'b0, o_wb_valid);
		check_flag("reset", "wb_we", 1'b0, o_wb_we);
		check_word("reset", "retired_count", '0, o_retired_count);
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////
	initial
	begin : main_seq
		bit load_ok;
		int gaps;
		int idx;
		i_rst_n       = 1'b0;
		i_instr_valid = 1'b0;
		i_instr       = '0;
		rng_state     = 32'd59905;
		cycle_limit   = 0;
		pass_count    = 0;
		fail_count    = 0;
		load_program(load_ok);
		if (!load_ok)
			fail_count++;
		else
		begin
			// issue slots plus worst-case idle plus margin
			cycle_limit = 3 * instr_list.size() + 2 * instr_list.size() + 10;
			test_ok = 1'b1;
			repeat (2)
			begin
				@(negedge i_clk);
				check_reset_state();
			end
			i_rst_n = 1'b1;
			@(negedge i_clk);
			check_reset_state();
			finish_test("reset");
			for (idx = 0; idx < instr_list.size(); idx++)
			begin
				// zero to two bubbles shift the forwarding distance
				rng_state = xorshift32(rng_state);
				gaps = int'(rng_state % 32'd3);
				repeat (gaps)
				begin
					i_instr_valid = 1'b0;
					i_instr       = '0;
					next_cycle();
				end
				i_instr_valid = 1'b1;
				i_instr       = instr_list[idx];
				pending.push_back(idx);
				next_cycle();
			end
			i_instr_valid = 1'b0;
			i_instr       = '0;
			// drain the pipeline
			while (pending.size() != 0)
				next_cycle();
			repeat (3)
				next_cycle();
			test_ok = 1'b1;
			check_word("retired_count", "count", mips_lite_pkg::word_t'(instr_list.size()),
				o_retired_count);
			finish_test("retired_count");
		end
		$display("tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	// cycle counter against the run length limit
	initial
	begin : watchdog
		int cycles;
		cycles = 0;
		wait (cycle_limit > 0);
		while (cycles < cycle_limit)
		begin
			@(posedge i_clk);
			cycles++;
		end
		$display("timeout after %0d cycles with %0d instructions still pending", cycles,
			pending.size());
		$display("Test failed");
		$finish;
	end

endmodule

// ==== verification/mips_lite_testdata.txt ====
// name instr we dest data
// instr and data in hex, we and dest in decimal, dest and data ignored when we is 0
addi_r1_pos      20010005 1 1  00000005
addi_r2_neg      2002FFFD 1 2  FFFFFFFD
add_r3           00221820 1 3  00000002
sub_r4           00612022 1 4  FFFFFFFD
ori_r5_zext      34058F0F 1 5  00008F0F
andi_r6_zext     3046F0F0 1 6  0000F0F0
xori_r7_zext     38478001 1 7  FFFF7FFC
lui_r8           3C08ABCD 1 8  ABCD0000
slti_r9_true     2849FFFE 1 9  00000001
slti_r10_false   282AFFFF 1 10 00000000
and_r11          00A65824 1 11 00008000
or_r12           01686025 1 12 ABCD8000
xor_r13          01876826 1 13 5432FFFC
slt_r14_true     0041702A 1 14 00000001
slt_r15_false    01A4782A 1 15 00000000
sll_r16          000D8100 1 16 432FFFC0
srl_r17          00108A02 1 17 00432FFF
srl_r18_logical  000297C2 1 18 00000001
addi_r0_nowrite  20200007 0 0  00000000
add_r19_read_r0  00019820 1 19 00000005
bad_opcode       8C250004 0 0  00000000
bad_funct        00213021 0 0  00000000
or_r20_unchanged 00A6A025 1 20 0000FFFF
sub_r21          0293A822 1 21 0000FFFA
add_r21_self     02B5A820 1 21 0001FFF4
add_r22          02B5B020 1 22 0003FFE8

// ==== mips_lite.f ====
hdl/mips_lite_pkg.sv
hdl/control_unit.sv
hdl/register_bank.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/writeback_stage.sv
hdl/mips_lite_top.sv
verification/mips_lite_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the mips lite testbench with verilator
set -eo pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary -j 0 --top-module mips_lite_tb -f mips_lite.f -o mips_lite_sim

./obj_dir/mips_lite_sim | tee sim.log

if grep -qx "Test completed successfully" sim.log
then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see sim.log"
	exit 1
fi
